// File: wb_types_pkg.sv
package wb_types_pkg;

    // register file geometry
    localparam int unsigned rf_depth = 32;
    localparam int unsigned rf_idx_w = $clog2(rf_depth);

    localparam int unsigned word_w = 32;

    // data and address word
    typedef logic [word_w-1:0] word_t;

    // architectural register number
    typedef logic [rf_idx_w-1:0] reg_idx_t;

    // added to the result of a link instruction
    localparam int unsigned link_offset = 4;

endpackage

// File: exc_pkg.sv
package exc_pkg;

    localparam int unsigned vppn_w = 19;

    // page number, low bits of the bad address
    typedef logic [vppn_w-1:0] vppn_t;

    typedef enum logic [6:0] {
        int_exc = 7'h00,
        pil     = 7'h01,
        pis     = 7'h02,
        pif     = 7'h03,
        pme     = 7'h04,
        ppi     = 7'h07,
        adef    = 7'h08,
        ale     = 7'h09,
        sys     = 7'h0b,
        brk     = 7'h0c,
        ine     = 7'h0d,
        tlbr    = 7'h3f
    } ecode_t;

    // codes that latch the faulting address
    function automatic logic sets_badv(input ecode_t code);
        case (code)
            pil, pis, pif, pme, ppi, adef, ale, tlbr: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // translation faults only, no alignment faults
    function automatic logic sets_vppn(input ecode_t code);
        case (code)
            pil, pis, pif, pme, ppi, tlbr: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

endpackage

// File: wb_lane_if.sv
interface wb_lane_if;

    logic                     valid;
    logic                     we;
    wb_types_pkg::reg_idx_t   rd;
    wb_types_pkg::word_t      data;

    // result collector side
    modport src (
        output valid, we, rd, data
    );

    // register file side
    modport dst (
        input valid, we, rd, data
    );

endinterface

// File: wb_result_collect.sv
module wb_result_collect #(
    parameter int data_w = 32
) (
    input  logic                   clk,
    input  logic                   aresetn,
    // lane 0
    input  logic [data_w-1:0]      res0,
    input  logic                   res0_valid,
    input  wb_types_pkg::reg_idx_t rd0,
    input  logic                   link0,
    input  logic                   csr_op0,
    input  logic [data_w-1:0]      csr_data,
    input  logic                   csr_ready,
    // divider
    input  logic                   div_op0,
    input  logic                   div_op1,
    input  logic                   rem_sel0,
    input  logic                   rem_sel1,
    input  logic [data_w-1:0]      quotient,
    input  logic [data_w-1:0]      remainder,
    input  logic                   div_ready,
    // lane 1
    input  logic [data_w-1:0]      res1,
    input  logic                   res1_valid,
    input  wb_types_pkg::reg_idx_t rd1,
    // load return
    input  wb_types_pkg::reg_idx_t load_rd,
    input  logic [data_w-1:0]      load_data,
    input  logic                   load_ready,
    wb_lane_if.src                 lane0,
    wb_lane_if.src                 lane1,
    wb_lane_if.src                 lane2
);

    logic [data_w-1:0] link_add;
    logic [data_w-1:0] sel0_data;
    logic [data_w-1:0] sel1_data;
    logic              sel0_valid;
    logic              sel0_we;
    logic              sel1_valid;
    logic              sel1_we;

    logic [data_w-1:0] data0_q;
    logic [data_w-1:0] data1_q;
    logic [data_w-1:0] data2_q;
    wb_types_pkg::reg_idx_t rd0_q;
    wb_types_pkg::reg_idx_t rd1_q;
    wb_types_pkg::reg_idx_t rd2_q;
    logic [2:0] valid_q;
    logic [2:0] we_q;

    assign link_add = link0 ? data_w'(wb_types_pkg::link_offset) : '0;

    // lane 0 priority: alu result, then csr read, then divide
    always_comb begin
        sel0_data  = res0 + link_add;
        sel0_valid = 1'b1;
        sel0_we    = 1'b1;
        if (!res0_valid) begin
            if (csr_op0) begin
                sel0_data = csr_data;
                sel0_we   = csr_ready;
            end else if (div_op0) begin
                sel0_data = rem_sel0 ? remainder : quotient;
                sel0_we   = div_ready;
            end else begin
                sel0_valid = 1'b0;
                sel0_we    = 1'b0;
            end
        end
    end

    always_comb begin
        sel1_data  = res1;
        sel1_valid = res1_valid | div_op1;
        sel1_we    = res1_valid | (div_op1 & div_ready);
        if (!res1_valid && div_op1) begin
            sel1_data = rem_sel1 ? remainder : quotient;
        end
    end

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            valid_q <= '0;
            we_q    <= '0;
        end else begin
            valid_q <= {load_ready, sel1_valid, sel0_valid};
            we_q    <= {load_ready, sel1_we, sel0_we};
        end
    end

    always_ff @(posedge clk) begin
        data0_q <= sel0_data;
        rd0_q   <= rd0;
        data1_q <= sel1_data;
        rd1_q   <= rd1;
        // hold the last load until the next one returns
        if (load_ready) begin
            data2_q <= load_data;
            rd2_q   <= load_rd;
        end
    end

    assign lane0.valid = valid_q[0];
    assign lane0.we    = we_q[0];
    assign lane0.rd    = rd0_q;
    assign lane0.data  = data0_q;

    assign lane1.valid = valid_q[1];
    assign lane1.we    = we_q[1];
    assign lane1.rd    = rd1_q;
    assign lane1.data  = data1_q;

    assign lane2.valid = valid_q[2];
    assign lane2.we    = we_q[2];
    assign lane2.rd    = rd2_q;
    assign lane2.data  = data2_q;

endmodule

// File: ex2_stall_ctrl.sv
module ex2_stall_ctrl (
    input  logic clk,
    input  logic aresetn,
    input  logic lanes_empty,
    input  logic div_op0,
    input  logic div_op1,
    input  logic csr_op0,
    input  logic div_ready,
    input  logic csr_ready,
    input  logic load_issue,
    input  logic dcache_ready,
    output logic ex2_allowin
);

    typedef enum logic [1:0] {
        stall_idle,
        stall_long,
        stall_load
    } stall_state_t;

    stall_state_t state;
    stall_state_t state_next;
    logic [1:0]   load_buf;
    logic         long_op;
    logic         long_done;
    logic         load_wait;

    assign long_op   = div_op0 | div_op1 | csr_op0;
    assign long_done = div_ready | csr_ready;

    // a load held in stage two keeps the buffer frozen
    assign load_wait = load_buf[1] | (state == stall_load);

    assign ex2_allowin = lanes_empty | long_done | dcache_ready | (!load_wait && !long_op);

    always_comb begin
        state_next = stall_idle;
        if (!ex2_allowin) begin
            state_next = long_op ? stall_long : stall_load;
        end
    end

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            state <= stall_idle;
        end else begin
            state <= state_next;
        end
    end

    // load pipe tracking, moves with the stage
    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            load_buf <= '0;
        end else if (ex2_allowin) begin
            load_buf <= {load_buf[0], load_issue};
        end
    end

endmodule

// File: exc_commit.sv
module exc_commit (
    input  logic                clk,
    input  logic                aresetn,
    input  logic                exc_flag_in,
    input  exc_pkg::ecode_t     ecode_in,
    input  wb_types_pkg::word_t badv_in,
    input  wb_types_pkg::word_t era_in,
    input  logic                cpu_interrupt,
    input  wb_types_pkg::word_t eentry,
    input  wb_types_pkg::word_t tlbrentry,
    output logic                exc_flag_out,
    output exc_pkg::ecode_t     ecode_out,
    output wb_types_pkg::word_t badv_out,
    output logic                wen_badv,
    output wb_types_pkg::word_t era_out,
    output logic                wen_era,
    output exc_pkg::vppn_t      vppn_out,
    output logic                wen_vppn,
    output logic                tlb_exception,
    output wb_types_pkg::word_t trap_pc,
    output logic                flush_all
);

    logic take_exc;
    logic badv_hit;
    logic vppn_hit;
    logic tlb_hit;

    // interrupts count as exceptions for flush and era
    assign take_exc = exc_flag_in | cpu_interrupt;

    assign badv_hit = exc_flag_in & exc_pkg::sets_badv(ecode_in);
    assign vppn_hit = exc_flag_in & exc_pkg::sets_vppn(ecode_in);
    assign tlb_hit  = exc_flag_in & (ecode_in == exc_pkg::tlbr);

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            exc_flag_out  <= 1'b0;
            wen_badv      <= 1'b0;
            wen_era       <= 1'b0;
            wen_vppn      <= 1'b0;
            tlb_exception <= 1'b0;
        end else begin
            exc_flag_out  <= take_exc;
            wen_badv      <= badv_hit;
            wen_era       <= take_exc;
            wen_vppn      <= vppn_hit;
            tlb_exception <= tlb_hit;
        end
    end

    // record fields, qualified by the enables above
    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            ecode_out <= exc_pkg::int_exc;
            badv_out  <= '0;
            era_out   <= '0;
            vppn_out  <= '0;
        end else begin
            ecode_out <= ecode_in;
            badv_out  <= badv_in;
            era_out   <= era_in;
            vppn_out  <= badv_in[exc_pkg::vppn_w-1:0];
        end
    end

    // tlb refill has its own entry point
    assign trap_pc = tlb_exception ? tlbrentry : eentry;

    assign flush_all = exc_flag_out;

endmodule

// File: wb_regfile.sv
module wb_regfile #(
    parameter int data_w = 32
) (
    input  logic                   clk,
    input  logic                   aresetn,
    wb_lane_if.dst                 lane0,
    wb_lane_if.dst                 lane1,
    wb_lane_if.dst                 lane2,
    input  wb_types_pkg::reg_idx_t raddr,
    output logic [data_w-1:0]      rdata
);

    logic [data_w-1:0] regs [wb_types_pkg::rf_depth];

    logic wr0;
    logic wr1;
    logic wr2;

    // r0 is hardwired, never written
    assign wr0 = lane0.valid & lane0.we & (lane0.rd != '0);
    assign wr1 = lane1.valid & lane1.we & (lane1.rd != '0);
    assign wr2 = lane2.valid & lane2.we & (lane2.rd != '0);

    // later ports override earlier ones on the same rd
    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            for (int i = 0; i < wb_types_pkg::rf_depth; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wr0) begin
                regs[lane0.rd] <= lane0.data;
            end
            if (wr1) begin
                regs[lane1.rd] <= lane1.data;
            end
            if (wr2) begin
                regs[lane2.rd] <= lane2.data;
            end
        end
    end

    assign rdata = (raddr == '0) ? '0 : regs[raddr];

endmodule

// File: ex2_wb_top.sv
module ex2_wb_top (
    input  logic                   clk,
    input  logic                   aresetn,
    // lane 0
    input  wb_types_pkg::word_t    res0,
    input  logic                   res0_valid,
    input  wb_types_pkg::reg_idx_t rd0,
    input  logic                   link0,
    input  logic                   csr_op0,
    input  wb_types_pkg::word_t    csr_data,
    input  logic                   csr_ready,
    // divider
    input  logic                   div_op0,
    input  logic                   div_op1,
    input  logic                   rem_sel0,
    input  logic                   rem_sel1,
    input  wb_types_pkg::word_t    quotient,
    input  wb_types_pkg::word_t    remainder,
    input  logic                   div_ready,
    // lane 1
    input  wb_types_pkg::word_t    res1,
    input  logic                   res1_valid,
    input  wb_types_pkg::reg_idx_t rd1,
    // loads
    input  logic                   load_issue,
    input  wb_types_pkg::reg_idx_t load_rd,
    input  wb_types_pkg::word_t    load_data,
    input  logic                   load_ready,
    input  logic                   dcache_ready,
    input  logic                   lanes_empty,
    // exceptions
    input  logic                   exc_flag_in,
    input  exc_pkg::ecode_t        ecode_in,
    input  wb_types_pkg::word_t    badv_in,
    input  wb_types_pkg::word_t    era_in,
    input  logic                   cpu_interrupt,
    input  wb_types_pkg::word_t    eentry,
    input  wb_types_pkg::word_t    tlbrentry,
    output logic                   ex2_allowin,
    output logic                   flush_all,
    output exc_pkg::ecode_t        ecode_out,
    output logic                   exc_flag_out,
    output wb_types_pkg::word_t    badv_out,
    output logic                   wen_badv,
    output wb_types_pkg::word_t    era_out,
    output logic                   wen_era,
    output exc_pkg::vppn_t         vppn_out,
    output logic                   wen_vppn,
    output logic                   tlb_exception,
    output wb_types_pkg::word_t    trap_pc,
    // register file observation
    input  wb_types_pkg::reg_idx_t rf_raddr,
    output wb_types_pkg::word_t    rf_rdata
);

    localparam int data_w = $bits(wb_types_pkg::word_t);

    wb_lane_if lane0 ();
    wb_lane_if lane1 ();
    wb_lane_if lane2 ();

    wb_result_collect #(
        .data_w (data_w)
    ) u_collect (
        .clk        (clk),
        .aresetn    (aresetn),
        .res0       (res0),
        .res0_valid (res0_valid),
        .rd0        (rd0),
        .link0      (link0),
        .csr_op0    (csr_op0),
        .csr_data   (csr_data),
        .csr_ready  (csr_ready),
        .div_op0    (div_op0),
        .div_op1    (div_op1),
        .rem_sel0   (rem_sel0),
        .rem_sel1   (rem_sel1),
        .quotient   (quotient),
        .remainder  (remainder),
        .div_ready  (div_ready),
        .res1       (res1),
        .res1_valid (res1_valid),
        .rd1        (rd1),
        .load_rd    (load_rd),
        .load_data  (load_data),
        .load_ready (load_ready),
        .lane0      (lane0.src),
        .lane1      (lane1.src),
        .lane2      (lane2.src)
    );

    ex2_stall_ctrl u_stall (
        .clk          (clk),
        .aresetn      (aresetn),
        .lanes_empty  (lanes_empty),
        .div_op0      (div_op0),
        .div_op1      (div_op1),
        .csr_op0      (csr_op0),
        .div_ready    (div_ready),
        .csr_ready    (csr_ready),
        .load_issue   (load_issue),
        .dcache_ready (dcache_ready),
        .ex2_allowin  (ex2_allowin)
    );

    exc_commit u_exc (
        .clk           (clk),
        .aresetn       (aresetn),
        .exc_flag_in   (exc_flag_in),
        .ecode_in      (ecode_in),
        .badv_in       (badv_in),
        .era_in        (era_in),
        .cpu_interrupt (cpu_interrupt),
        .eentry        (eentry),
        .tlbrentry     (tlbrentry),
        .exc_flag_out  (exc_flag_out),
        .ecode_out     (ecode_out),
        .badv_out      (badv_out),
        .wen_badv      (wen_badv),
        .era_out       (era_out),
        .wen_era       (wen_era),
        .vppn_out      (vppn_out),
        .wen_vppn      (wen_vppn),
        .tlb_exception (tlb_exception),
        .trap_pc       (trap_pc),
        .flush_all     (flush_all)
    );

    wb_regfile #(
        .data_w (data_w)
    ) u_regfile (
        .clk     (clk),
        .aresetn (aresetn),
        .lane0   (lane0.dst),
        .lane1   (lane1.dst),
        .lane2   (lane2.dst),
        .raddr   (rf_raddr),
        .rdata   (rf_rdata)
    );

endmodule

// File: ex2_wb_assert.sv
module ex2_wb_assert (
    input logic                clk,
    input logic                aresetn,
    input logic                exc_flag_in,
    input exc_pkg::ecode_t     ecode_in,
    input wb_types_pkg::word_t badv_in,
    input wb_types_pkg::word_t era_in,
    input logic                cpu_interrupt,
    input wb_types_pkg::word_t eentry,
    input wb_types_pkg::word_t tlbrentry,
    input logic                exc_flag_out,
    input exc_pkg::ecode_t     ecode_out,
    input wb_types_pkg::word_t badv_out,
    input logic                wen_badv,
    input wb_types_pkg::word_t era_out,
    input logic                wen_era,
    input exc_pkg::vppn_t      vppn_out,
    input logic                wen_vppn,
    input logic                tlb_exception,
    input wb_types_pkg::word_t trap_pc,
    input logic                flush_all,
    input logic                ex2_allowin,
    input logic                lanes_empty,
    input logic                div_op0,
    input logic                div_op1,
    input logic                div_ready,
    input logic                csr_ready,
    input logic                load_issue,
    input logic                dcache_ready
);
    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fail_count = 0;

    logic       badv_exp;
    logic       vppn_exp;
    logic       tlbr_taken;
    logic       take_exp;
    logic       no_release;
    logic [1:0] load_pipe;

    // faults that carry a bad address
    function automatic logic addr_fault(input exc_pkg::ecode_t code);
        return code == exc_pkg::pil || code == exc_pkg::pis || code == exc_pkg::pif
            || code == exc_pkg::pme || code == exc_pkg::ppi || code == exc_pkg::adef
            || code == exc_pkg::ale || code == exc_pkg::tlbr;
    endfunction

    // alignment faults have no page number
    function automatic logic page_fault(input exc_pkg::ecode_t code);
        return addr_fault(code) && code != exc_pkg::adef && code != exc_pkg::ale;
    endfunction

    assign badv_exp   = exc_flag_in && addr_fault(ecode_in);
    assign vppn_exp   = exc_flag_in && page_fault(ecode_in);
    assign tlbr_taken = exc_flag_in && ecode_in == exc_pkg::tlbr;
    assign take_exp   = exc_flag_in || cpu_interrupt;
    assign no_release = !lanes_empty && !div_ready && !csr_ready && !dcache_ready;

    // where an issued load sits in the stage pipe
    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            load_pipe <= '0;
        end else if (ex2_allowin) begin
            load_pipe <= {load_pipe[0], load_issue};
        end
    end

    a_wen_badv: assert property (@(posedge clk) disable iff (!aresetn)
        exc_flag_in |=> wen_badv == $past(badv_exp))
    else begin
        $error("wen_badv does not follow the exception code");
        fail_count++;
    end

    a_wen_vppn: assert property (@(posedge clk) disable iff (!aresetn)
        exc_flag_in |=> wen_vppn == $past(vppn_exp))
    else begin
        $error("wen_vppn does not follow the exception code");
        fail_count++;
    end

    a_no_fault_wen: assert property (@(posedge clk) disable iff (!aresetn)
        !exc_flag_in |=> !wen_badv && !wen_vppn)
    else begin
        $error("address enables raised without an exception");
        fail_count++;
    end

    a_vppn: assert property (@(posedge clk) disable iff (!aresetn)
        exc_flag_in |=> vppn_out == $past(badv_in[18:0]))
    else begin
        $error("vppn_out is not the low bits of the bad address");
        fail_count++;
    end

    a_flush: assert property (@(posedge clk) disable iff (!aresetn)
        1'b1 |=> flush_all == $past(take_exp))
    else begin
        $error("flush_all does not follow the exception flag");
        fail_count++;
    end

    a_record: assert property (@(posedge clk) disable iff (!aresetn)
        1'b1 |=> exc_flag_out == $past(take_exp) && wen_era == $past(take_exp)
            && ecode_out == $past(ecode_in) && badv_out == $past(badv_in)
            && era_out == $past(era_in) && tlb_exception == $past(tlbr_taken))
    else begin
        $error("exception record fields were not registered from the inputs");
        fail_count++;
    end

    // refill entry only for a registered tlbr
    a_trap_pc: assert property (@(posedge clk) disable iff (!aresetn)
        1'b1 |=> trap_pc == ($past(tlbr_taken) ? tlbrentry : eentry))
    else begin
        $error("trap_pc picked the wrong entry");
        fail_count++;
    end

    a_int_only: assert property (@(posedge clk) disable iff (!aresetn)
        cpu_interrupt && !exc_flag_in |=> wen_era && exc_flag_out && !wen_badv)
    else begin
        $error("interrupt alone gave the wrong enables");
        fail_count++;
    end

    a_div_stall: assert property (@(posedge clk) disable iff (!aresetn)
        (div_op0 || div_op1) && no_release |-> !ex2_allowin)
    else begin
        $error("allowin high while a divide is pending");
        fail_count++;
    end

    a_load_stall: assert property (@(posedge clk) disable iff (!aresetn)
        load_pipe[1] && no_release |-> !ex2_allowin)
    else begin
        $error("allowin high while a load waits for the cache");
        fail_count++;
    end

    a_empty: assert property (@(posedge clk) disable iff (!aresetn)
        lanes_empty |-> ex2_allowin)
    else begin
        $error("allowin low with both lanes empty");
        fail_count++;
    end

    a_reset_allowin: assert property (@(posedge clk)
        $rose(aresetn) |-> ex2_allowin)
    else begin
        $error("allowin low right after reset");
        fail_count++;
    end

endmodule

bind ex2_wb_top ex2_wb_assert u_assert (.*);

// File: tb_ex2_wb.sv
module tb_ex2_wb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int reset_cycles = 16;
    localparam int cycle_limit  = reset_cycles + 6 * 200;

    logic                   clk;
    logic                   aresetn;
    wb_types_pkg::word_t    res0;
    logic                   res0_valid;
    wb_types_pkg::reg_idx_t rd0;
    logic                   link0;
    logic                   csr_op0;
    wb_types_pkg::word_t    csr_data;
    logic                   csr_ready;
    logic                   div_op0;
    logic                   div_op1;
    logic                   rem_sel0;
    logic                   rem_sel1;
    wb_types_pkg::word_t    quotient;
    wb_types_pkg::word_t    remainder;
    logic                   div_ready;
    wb_types_pkg::word_t    res1;
    logic                   res1_valid;
    wb_types_pkg::reg_idx_t rd1;
    logic                   load_issue;
    wb_types_pkg::reg_idx_t load_rd;
    wb_types_pkg::word_t    load_data;
    logic                   load_ready;
    logic                   dcache_ready;
    logic                   lanes_empty;
    logic                   exc_flag_in;
    exc_pkg::ecode_t        ecode_in;
    wb_types_pkg::word_t    badv_in;
    wb_types_pkg::word_t    era_in;
    logic                   cpu_interrupt;
    wb_types_pkg::word_t    eentry;
    wb_types_pkg::word_t    tlbrentry;
    logic                   ex2_allowin;
    logic                   flush_all;
    exc_pkg::ecode_t        ecode_out;
    logic                   exc_flag_out;
    wb_types_pkg::word_t    badv_out;
    logic                   wen_badv;
    wb_types_pkg::word_t    era_out;
    logic                   wen_era;
    exc_pkg::vppn_t         vppn_out;
    logic                   wen_vppn;
    logic                   tlb_exception;
    wb_types_pkg::word_t    trap_pc;
    wb_types_pkg::reg_idx_t rf_raddr;
    wb_types_pkg::word_t    rf_rdata;

    // expected register contents
    wb_types_pkg::word_t ref_rf [32];
    exc_pkg::ecode_t     code_tab [12];
    logic [31:0]         seed;
    int                  cycles = 0;
    int                  errors = 0;
    int                  checks = 0;
    int                  test_no = 0;
    int                  test_err = 0;
    int                  fails;

    ex2_wb_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: the run went past %0d cycles", cycle_limit);
            $display("sim failed");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        seed = xorshift(seed);
        return seed;
    endfunction

    function automatic wb_types_pkg::reg_idx_t rand_rd();
        logic [31:0] r;
        r = next_rand();
        return r[4:0];
    endfunction

    task automatic idle_inputs();
        res0_valid    = 1'b0;
        link0         = 1'b0;
        csr_op0       = 1'b0;
        csr_ready     = 1'b0;
        div_op0       = 1'b0;
        div_op1       = 1'b0;
        rem_sel0      = 1'b0;
        rem_sel1      = 1'b0;
        div_ready     = 1'b0;
        res1_valid    = 1'b0;
        load_issue    = 1'b0;
        load_ready    = 1'b0;
        dcache_ready  = 1'b0;
        lanes_empty   = 1'b1;
        exc_flag_in   = 1'b0;
        cpu_interrupt = 1'b0;
    endtask

    task automatic init_inputs();
        idle_inputs();
        // busy lanes so allowin at reset release comes from the stall logic
        lanes_empty = 1'b0;
        res0      = '0;
        rd0       = '0;
        csr_data  = '0;
        quotient  = '0;
        remainder = '0;
        res1      = '0;
        rd1       = '0;
        load_rd   = '0;
        load_data = '0;
        ecode_in  = exc_pkg::int_exc;
        badv_in   = '0;
        era_in    = '0;
        eentry    = 32'h1c00_8000;
        tlbrentry = 32'h1c00_f000;
        rf_raddr  = '0;
    endtask

    // r0 never changes
    task automatic ref_write(input wb_types_pkg::reg_idx_t rd, input wb_types_pkg::word_t value);
        if (rd != 5'd0) begin
            ref_rf[rd] = value;
        end
    endtask

    task automatic expect_reg(input wb_types_pkg::reg_idx_t idx);
        rf_raddr = idx;
        #1;
        checks++;
        if (rf_rdata !== ref_rf[idx]) begin
            $display("MISMATCH rf_rdata reg %0d: got %h expected %h", idx, rf_rdata, ref_rf[idx]);
            errors++;
        end
    endtask

    // captured at the next edge and written one edge later
    task automatic retire_check(input wb_types_pkg::reg_idx_t rd_a,
                                input wb_types_pkg::reg_idx_t rd_b);
        @(negedge clk);
        idle_inputs();
        @(negedge clk);
        expect_reg(rd_a);
        expect_reg(rd_b);
    endtask

    task automatic end_test(input string name);
        test_no++;
        $display("test %0d %s: %0d errors", test_no, name, errors - test_err);
        test_err = errors;
    endtask

    task automatic run_alu_lanes();
        logic [31:0] r;
        for (int i = 0; i < 8; i++) begin
            r           = next_rand();
            res0        = next_rand();
            res1        = next_rand();
            rd0         = (i == 0) ? 5'd0 : rand_rd();
            rd1         = rand_rd();
            link0       = r[0];
            res0_valid  = 1'b1;
            res1_valid  = 1'b1;
            lanes_empty = 1'b0;
            ref_write(rd0, res0 + (link0 ? 32'd4 : 32'd0));
            ref_write(rd1, res1);
            retire_check(rd0, rd1);
        end
        end_test("alu_lanes");
    endtask

    task automatic run_csr_div();
        wb_types_pkg::reg_idx_t rd;
        logic [31:0] r;
        for (int i = 0; i < 4; i++) begin
            rd          = rand_rd() | 5'd1;
            rd0         = rd;
            csr_op0     = 1'b1;
            csr_ready   = 1'b0;
            csr_data    = next_rand();
            lanes_empty = 1'b0;
            @(negedge clk);
            csr_ready = 1'b1;
            csr_data  = next_rand();
            @(negedge clk);
            idle_inputs();
            // the unready cycle must not have written
            expect_reg(rd);
            ref_write(rd, csr_data);
            @(negedge clk);
            expect_reg(rd);

            r           = next_rand();
            div_op0     = 1'b1;
            div_op1     = 1'b1;
            rem_sel0    = r[0];
            rem_sel1    = r[1];
            rd0         = rand_rd();
            rd1         = rand_rd();
            quotient    = next_rand();
            remainder   = next_rand();
            lanes_empty = 1'b0;
            repeat (2) @(negedge clk);
            expect_reg(rd0);
            expect_reg(rd1);
            div_ready = 1'b1;
            quotient  = next_rand();
            remainder = next_rand();
            ref_write(rd0, rem_sel0 ? remainder : quotient);
            ref_write(rd1, rem_sel1 ? remainder : quotient);
            retire_check(rd0, rd1);
        end
        end_test("csr_div");
    endtask

    task automatic run_load_collide();
        wb_types_pkg::reg_idx_t rd;
        logic [31:0] r;
        for (int i = 0; i < 4; i++) begin
            load_issue   = 1'b1;
            lanes_empty  = 1'b0;
            dcache_ready = 1'b0;
            @(negedge clk);
            load_issue = 1'b0;
            // load sits in stage two until the cache answers
            repeat (3) @(negedge clk);
            dcache_ready = 1'b1;
            load_ready   = 1'b1;
            load_rd      = rand_rd() | 5'd1;
            load_data    = next_rand();
            ref_write(load_rd, load_data);
            retire_check(load_rd, 5'd0);

            r          = next_rand();
            rd         = rand_rd() | 5'd1;
            rd0        = rd;
            rd1        = rd;
            load_rd    = rd;
            res0       = next_rand();
            res1       = next_rand();
            load_data  = next_rand();
            res0_valid = 1'b1;
            res1_valid = 1'b1;
            load_ready = r[0];
            ref_write(rd, res0);
            ref_write(rd, res1);
            if (load_ready) begin
                ref_write(rd, load_data);
            end
            retire_check(rd, 5'd0);
        end
        end_test("load_collide");
    endtask

    task automatic run_exc_codes();
        logic [31:0] r;
        int idx;
        for (int i = 0; i < 40; i++) begin
            r           = next_rand();
            idx         = int'(next_rand() % 32'd12);
            exc_flag_in = r[0] | r[1];
            ecode_in    = code_tab[idx];
            badv_in     = next_rand();
            era_in      = next_rand();
            @(negedge clk);
        end
        idle_inputs();
        @(negedge clk);
        end_test("exc_codes");
    endtask

    task automatic run_trap_int();
        int idx;
        for (int i = 0; i < 8; i++) begin
            idx         = int'(next_rand() % 32'd11);
            exc_flag_in = 1'b1;
            ecode_in    = (i % 2 == 0) ? exc_pkg::tlbr : code_tab[idx];
            badv_in     = next_rand();
            era_in      = next_rand();
            @(negedge clk);
            exc_flag_in   = 1'b0;
            cpu_interrupt = 1'b1;
            @(negedge clk);
            cpu_interrupt = 1'b0;
            @(negedge clk);
        end
        end_test("trap_int");
    endtask

    task automatic run_allowin();
        for (int i = 0; i < 3; i++) begin
            rd0         = '0;
            rd1         = '0;
            div_op0     = (i != 1);
            div_op1     = (i != 0);
            lanes_empty = 1'b0;
            repeat (3) @(negedge clk);
            lanes_empty = 1'b1;
            @(negedge clk);
            lanes_empty = 1'b0;
            div_ready   = 1'b1;
            #1;
            if (!ex2_allowin) begin
                $display("allowin stayed low after the divide finished");
                errors++;
            end
            @(negedge clk);
            idle_inputs();
            @(negedge clk);
        end
        load_issue  = 1'b1;
        lanes_empty = 1'b0;
        @(negedge clk);
        load_issue = 1'b0;
        repeat (3) @(negedge clk);
        lanes_empty = 1'b1;
        @(negedge clk);
        idle_inputs();
        @(negedge clk);
        end_test("allowin");
    endtask

    initial begin
        seed = 32'h1835;
        code_tab = '{exc_pkg::int_exc, exc_pkg::pil, exc_pkg::pis, exc_pkg::pif,
                     exc_pkg::pme, exc_pkg::ppi, exc_pkg::adef, exc_pkg::ale,
                     exc_pkg::sys, exc_pkg::brk, exc_pkg::ine, exc_pkg::tlbr};
        for (int i = 0; i < 32; i++) begin
            ref_rf[i] = '0;
        end
        init_inputs();
        aresetn = 1'b0;
        repeat (reset_cycles) @(negedge clk);
        aresetn = 1'b1;

        run_alu_lanes();
        run_csr_div();
        run_load_collide();
        run_exc_codes();
        run_trap_int();
        run_allowin();

        fails = errors + int'(DUT.u_assert.fail_count);
        $display("%0d tests, %0d register checks, %0d check errors, %0d assertion failures",
                 test_no, checks, errors, DUT.u_assert.fail_count);
        if (fails == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: ex2_wb_top.f
wb_types_pkg.sv
exc_pkg.sv
wb_lane_if.sv
wb_result_collect.sv
ex2_stall_ctrl.sv
exc_commit.sv
wb_regfile.sv
ex2_wb_top.sv
ex2_wb_assert.sv
tb_ex2_wb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_ex2_wb -f ex2_wb_top.f -o sim_ex2_wb || exit 1
out="$(./obj_dir/sim_ex2_wb)"
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "sim passed" && exit 0 || exit 1
